// ==== common/afu_consts.svh ====
// Widths and codes shared by the design; tag count must not exceed 2**AFU_TAG_WIDTH
`ifndef AFU_CONSTS_SVH
`define AFU_CONSTS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////
`define AFU_ADDR_WIDTH 32
`define AFU_CU_ID_WIDTH 8
`define AFU_TAG_WIDTH 8
`define AFU_CREDIT_WIDTH 8

//////////////////////////////
// Buffer and tag sizing
//////////////////////////////
`define AFU_TAG_COUNT 16
`define AFU_CMD_FIFO_DEPTH 8

//////////////////////////////
// Bus command opcodes
//////////////////////////////
`define AFU_CMD_CODE_WIDTH 13
`define AFU_CODE_READ_CL_NA 13'h0A00
`define AFU_CODE_WRITE_NA 13'h0D00

`endif

// ==== common/afu_cmd_pkg.sv ====
// Command-side types; widths come from afu_consts.svh, which must be on the include path
package afu_cmd_pkg;

	`include "afu_consts.svh"

	//////////////////////////////
	// Command payload fields
	//////////////////////////////

	// Effective address of a cache line
	typedef logic [`AFU_ADDR_WIDTH-1:0] addr_t;

	// Compute unit that asked for the command
	typedef logic [`AFU_CU_ID_WIDTH-1:0] cu_id_t;

	// Tag as seen on the bus
	typedef logic [`AFU_TAG_WIDTH-1:0] tag_t;

	// Bus opcode
	typedef logic [`AFU_CMD_CODE_WIDTH-1:0] cmd_code_t;

	//////////////////////////////
	// Command classes
	//////////////////////////////

	// Order matters, the arbiter rotates in this order
	typedef enum logic [1:0] {
		CLASS_WED,
		CLASS_WRITE,
		CLASS_READ
	} cmd_class_t;

endpackage

// ==== common/afu_rsp_pkg.sv ====
// Response-side and control types; response codes follow the bus encoding
package afu_rsp_pkg;

	`include "afu_consts.svh"

	// Credit count, also the width of the room offer
	typedef logic [`AFU_CREDIT_WIDTH-1:0] credit_t;

	//////////////////////////////
	// Bus response codes
	//////////////////////////////
	typedef enum logic [7:0] {
		RSP_DONE    = 8'h00,
		RSP_AERROR  = 8'h01,
		RSP_DERROR  = 8'h03,
		RSP_NLOCK   = 8'h04,
		RSP_NRES    = 8'h05,
		RSP_FLUSHED = 8'h06,
		RSP_FAULT   = 8'h07,
		RSP_FAILED  = 8'h08,
		RSP_PAGED   = 8'h0A
	} rsp_code_t;

	//////////////////////////////
	// Control state
	//////////////////////////////

	// Idle loads credits from room, run issues commands
	typedef enum logic [1:0] {
		CTL_IDLE,
		CTL_RUN
	} ctl_state_t;

endpackage

// ==== source/sync_fifo.sv ====
// First-word-fall-through FIFO; a push while full and a pop while empty are ignored
`timescale 1ns/1ps

`include "afu_consts.svh"

module sync_fifo #(
	parameter int WIDTH = $bits(afu_cmd_pkg::addr_t) + $bits(afu_cmd_pkg::cu_id_t),
	parameter int DEPTH = `AFU_CMD_FIFO_DEPTH
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             empty,
	output logic             full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	assign empty = (count == '0);
	assign full  = (count == CNT_W'(DEPTH));

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// Head of the queue, valid whenever not empty
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	//////////////////////////////
	// Pointers and fill level
	//////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Push and pop together leave the count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// ==== command/cmd_rr_arbiter.sv ====
// Round-robin over wed, write and read buffers; one grant per cycle, bus command registered
`timescale 1ns/1ps

`include "afu_consts.svh"

module cmd_rr_arbiter (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   issue_enable,
	input  logic                   wed_empty,
	input  logic                   write_empty,
	input  logic                   read_empty,
	input  afu_cmd_pkg::addr_t     wed_addr,
	input  afu_cmd_pkg::addr_t     write_addr,
	input  afu_cmd_pkg::addr_t     read_addr,
	input  afu_cmd_pkg::cu_id_t    wed_cu_id,
	input  afu_cmd_pkg::cu_id_t    write_cu_id,
	input  afu_cmd_pkg::cu_id_t    read_cu_id,
	input  afu_cmd_pkg::tag_t      free_tag,
	output logic                   wed_pop,
	output logic                   write_pop,
	output logic                   read_pop,
	output logic                   grant_valid,
	output afu_cmd_pkg::cmd_class_t grant_class,
	output logic                   command_valid,
	output afu_cmd_pkg::tag_t      command_tag,
	output afu_cmd_pkg::cmd_code_t command_code,
	output afu_cmd_pkg::addr_t     command_addr,
	output afu_cmd_pkg::cu_id_t    command_cu_id
);

	import afu_cmd_pkg::*;

	logic [2:0] request;
	cmd_class_t ptr;

	// Indexed by class encoding
	assign request = {!read_empty, !write_empty, !wed_empty};

	//////////////////////////////
	// Grant selection
	//////////////////////////////
	always_comb begin
		int   idx;
		logic found;
		found       = 1'b0;
		grant_class = CLASS_WED;
		// Walk from the pointer and take the first class with work
		for (int i = 0; i < 3; i++) begin
			idx = (int'(ptr) + i) % 3;
			if (!found && request[idx]) begin
				found       = 1'b1;
				grant_class = cmd_class_t'(idx);
			end
		end
		grant_valid = issue_enable && found;
	end

	assign wed_pop   = grant_valid && (grant_class == CLASS_WED);
	assign write_pop = grant_valid && (grant_class == CLASS_WRITE);
	assign read_pop  = grant_valid && (grant_class == CLASS_READ);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			ptr <= CLASS_WED;
		end else if (grant_valid) begin
			ptr <= (grant_class == CLASS_READ) ? CLASS_WED : cmd_class_t'(grant_class + 2'd1);
		end
	end

	//////////////////////////////
	// Bus command register
	//////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			command_valid <= 1'b0;
		end else begin
			command_valid <= grant_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (grant_valid) begin
			command_tag <= free_tag;
			case (grant_class)
				CLASS_WRITE: begin
					command_code  <= cmd_code_t'(`AFU_CODE_WRITE_NA);
					command_addr  <= write_addr;
					command_cu_id <= write_cu_id;
				end
				CLASS_READ: begin
					command_code  <= cmd_code_t'(`AFU_CODE_READ_CL_NA);
					command_addr  <= read_addr;
					command_cu_id <= read_cu_id;
				end
				default: begin
					// Work element is fetched with a plain line read
					command_code  <= cmd_code_t'(`AFU_CODE_READ_CL_NA);
					command_addr  <= wed_addr;
					command_cu_id <= wed_cu_id;
				end
			endcase
		end
	end

endmodule

// ==== command/issue_control.sv ====
// Enable FSM, shared credit counter and response input stage; one credit is always held back
`timescale 1ns/1ps

module issue_control (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  enabled_in,
	input  afu_rsp_pkg::credit_t  room,
	input  logic                  grant_valid,
	input  logic                  tag_available,
	input  logic                  any_pending,
	input  logic                  response_valid,
	input  afu_cmd_pkg::tag_t     response_tag,
	input  afu_rsp_pkg::rsp_code_t response_code,
	input  afu_rsp_pkg::credit_t  response_credits,
	output logic                  issue_enable,
	output logic                  rsp_stage_valid,
	output afu_cmd_pkg::tag_t     rsp_stage_tag,
	output afu_rsp_pkg::rsp_code_t rsp_stage_code
);

	import afu_rsp_pkg::*;

	ctl_state_t state;
	ctl_state_t state_next;
	credit_t    credits;
	credit_t    credit_add;
	credit_t    credit_sub;

	//////////////////////////////
	// Enable FSM
	//////////////////////////////
	always_comb begin
		state_next = state;
		case (state)
			CTL_IDLE: begin
				if (enabled_in) begin
					state_next = CTL_RUN;
				end
			end
			CTL_RUN: begin
				if (!enabled_in) begin
					state_next = CTL_IDLE;
				end
			end
			default: state_next = CTL_IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= CTL_IDLE;
		end else begin
			state <= state_next;
		end
	end

	//////////////////////////////
	// Credit counter
	//////////////////////////////
	assign credit_add = response_valid ? response_credits : '0;
	assign credit_sub = grant_valid ? credit_t'(1) : '0;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			credits <= '0;
		end else if (state == CTL_IDLE) begin
			// Bus room is only trusted while disabled
			credits <= room;
		end else begin
			credits <= credits + credit_add - credit_sub;
		end
	end

	// Last credit stays in reserve
	assign issue_enable = (state == CTL_RUN) && (credits > credit_t'(1))
		&& tag_available && any_pending;

	//////////////////////////////
	// Response input stage
	//////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rsp_stage_valid <= 1'b0;
		end else begin
			rsp_stage_valid <= response_valid;
		end
	end

	always_ff @(posedge clock) begin
		rsp_stage_tag  <= response_tag;
		rsp_stage_code <= response_code;
	end

endmodule

// ==== source/tag_table.sv ====
// Tag allocator and lookup; only the low tag bits index the table, upper bits are ignored
`timescale 1ns/1ps

`include "afu_consts.svh"

module tag_table (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    grant_valid,
	input  afu_cmd_pkg::cmd_class_t grant_class,
	input  afu_cmd_pkg::cu_id_t     grant_cu_id,
	input  logic                    rsp_stage_valid,
	input  afu_cmd_pkg::tag_t       rsp_stage_tag,
	input  afu_rsp_pkg::rsp_code_t  rsp_stage_code,
	output afu_cmd_pkg::tag_t       free_tag,
	output logic                    tag_available,
	output logic                    rsp_valid,
	output afu_cmd_pkg::cmd_class_t rsp_class,
	output afu_cmd_pkg::cu_id_t     rsp_cu_id,
	output afu_rsp_pkg::rsp_code_t  rsp_code,
	output logic                    rsp_error
);

	import afu_cmd_pkg::*;
	import afu_rsp_pkg::*;

	localparam int IDX_W = $clog2(`AFU_TAG_COUNT);

	logic [`AFU_TAG_COUNT-1:0] busy;
	cmd_class_t                class_mem [`AFU_TAG_COUNT];
	cu_id_t                    cu_mem [`AFU_TAG_COUNT];
	logic [IDX_W-1:0]          free_idx;
	logic [IDX_W-1:0]          rsp_idx;

	//////////////////////////////
	// Lowest free tag
	//////////////////////////////
	always_comb begin
		free_idx = '0;
		// Descending walk so the lowest free index wins
		for (int i = `AFU_TAG_COUNT - 1; i >= 0; i--) begin
			if (!busy[i]) begin
				free_idx = IDX_W'(i);
			end
		end
	end

	assign free_tag      = tag_t'(free_idx);
	assign tag_available = !(&busy);
	assign rsp_idx       = rsp_stage_tag[IDX_W-1:0];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy <= '0;
		end else begin
			if (rsp_stage_valid) begin
				busy[rsp_idx] <= 1'b0;
			end
			if (grant_valid) begin
				busy[free_idx] <= 1'b1;
			end
		end
	end

	// Class and requester per outstanding tag
	always_ff @(posedge clock) begin
		if (grant_valid) begin
			class_mem[free_idx] <= grant_class;
			cu_mem[free_idx]    <= grant_cu_id;
		end
	end

	//////////////////////////////
	// Response output
	//////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rsp_valid <= 1'b0;
			rsp_error <= 1'b0;
		end else begin
			rsp_valid <= rsp_stage_valid;
			rsp_error <= rsp_stage_valid && (rsp_stage_code != RSP_DONE);
		end
	end

	always_ff @(posedge clock) begin
		if (rsp_stage_valid) begin
			rsp_class <= class_mem[rsp_idx];
			rsp_cu_id <= cu_mem[rsp_idx];
			rsp_code  <= rsp_stage_code;
		end
	end

endmodule

// ==== source/afu_control.sv ====
// Command and response control top; the bus has no ready, so issue stops only on credits or tags
`timescale 1ns/1ps

module afu_control (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    enabled_in,
	input  afu_rsp_pkg::credit_t    room,
	input  logic                    wed_cmd_push,
	input  afu_cmd_pkg::addr_t      wed_cmd_addr,
	input  afu_cmd_pkg::cu_id_t     wed_cmd_cu_id,
	output logic                    wed_cmd_full,
	input  logic                    write_cmd_push,
	input  afu_cmd_pkg::addr_t      write_cmd_addr,
	input  afu_cmd_pkg::cu_id_t     write_cmd_cu_id,
	output logic                    write_cmd_full,
	input  logic                    read_cmd_push,
	input  afu_cmd_pkg::addr_t      read_cmd_addr,
	input  afu_cmd_pkg::cu_id_t     read_cmd_cu_id,
	output logic                    read_cmd_full,
	input  logic                    response_valid,
	input  afu_cmd_pkg::tag_t       response_tag,
	input  afu_rsp_pkg::rsp_code_t  response_code,
	input  afu_rsp_pkg::credit_t    response_credits,
	output logic                    command_valid,
	output afu_cmd_pkg::tag_t       command_tag,
	output afu_cmd_pkg::cmd_code_t  command_code,
	output afu_cmd_pkg::addr_t      command_addr,
	output afu_cmd_pkg::cu_id_t     command_cu_id,
	output logic                    rsp_valid,
	output afu_cmd_pkg::cmd_class_t rsp_class,
	output afu_cmd_pkg::cu_id_t     rsp_cu_id,
	output afu_rsp_pkg::rsp_code_t  rsp_code,
	output logic                    rsp_error
);

	import afu_cmd_pkg::*;
	import afu_rsp_pkg::*;

	localparam int CU_W   = $bits(cu_id_t);
	localparam int WORD_W = $bits(addr_t) + CU_W;

	logic [WORD_W-1:0] wed_head;
	logic [WORD_W-1:0] write_head;
	logic [WORD_W-1:0] read_head;
	logic              wed_empty;
	logic              write_empty;
	logic              read_empty;
	logic              wed_pop;
	logic              write_pop;
	logic              read_pop;
	logic              any_pending;
	logic              issue_enable;
	logic              grant_valid;
	cmd_class_t        grant_class;
	cu_id_t            grant_cu_id;
	tag_t              free_tag;
	logic              tag_available;
	logic              rsp_stage_valid;
	tag_t              rsp_stage_tag;
	rsp_code_t         rsp_stage_code;

	//////////////////////////////
	// Command buffers
	//////////////////////////////
	sync_fifo #(.WIDTH(WORD_W), .DEPTH(`AFU_CMD_FIFO_DEPTH)) u_wed_fifo (
		.clock(clock), .rstn(rstn), .push(wed_cmd_push),
		.data_in({wed_cmd_addr, wed_cmd_cu_id}), .pop(wed_pop),
		.data_out(wed_head), .empty(wed_empty), .full(wed_cmd_full)
	);

	sync_fifo #(.WIDTH(WORD_W), .DEPTH(`AFU_CMD_FIFO_DEPTH)) u_write_fifo (
		.clock(clock), .rstn(rstn), .push(write_cmd_push),
		.data_in({write_cmd_addr, write_cmd_cu_id}), .pop(write_pop),
		.data_out(write_head), .empty(write_empty), .full(write_cmd_full)
	);

	sync_fifo #(.WIDTH(WORD_W), .DEPTH(`AFU_CMD_FIFO_DEPTH)) u_read_fifo (
		.clock(clock), .rstn(rstn), .push(read_cmd_push),
		.data_in({read_cmd_addr, read_cmd_cu_id}), .pop(read_pop),
		.data_out(read_head), .empty(read_empty), .full(read_cmd_full)
	);

	assign any_pending = !wed_empty || !write_empty || !read_empty;

	// Requester of the granted head goes into the tag table
	always_comb begin
		case (grant_class)
			CLASS_WRITE: grant_cu_id = write_head[CU_W-1:0];
			CLASS_READ:  grant_cu_id = read_head[CU_W-1:0];
			default:     grant_cu_id = wed_head[CU_W-1:0];
		endcase
	end

	//////////////////////////////
	// Arbiter, control, tags
	//////////////////////////////
	cmd_rr_arbiter u_arbiter (
		.clock(clock), .rstn(rstn), .issue_enable(issue_enable),
		.wed_empty(wed_empty), .write_empty(write_empty), .read_empty(read_empty),
		.wed_addr(wed_head[WORD_W-1:CU_W]), .write_addr(write_head[WORD_W-1:CU_W]),
		.read_addr(read_head[WORD_W-1:CU_W]), .wed_cu_id(wed_head[CU_W-1:0]),
		.write_cu_id(write_head[CU_W-1:0]), .read_cu_id(read_head[CU_W-1:0]),
		.free_tag(free_tag), .wed_pop(wed_pop), .write_pop(write_pop), .read_pop(read_pop),
		.grant_valid(grant_valid), .grant_class(grant_class),
		.command_valid(command_valid), .command_tag(command_tag),
		.command_code(command_code), .command_addr(command_addr),
		.command_cu_id(command_cu_id)
	);

	issue_control u_issue_control (
		.clock(clock), .rstn(rstn), .enabled_in(enabled_in), .room(room),
		.grant_valid(grant_valid), .tag_available(tag_available),
		.any_pending(any_pending), .response_valid(response_valid),
		.response_tag(response_tag), .response_code(response_code),
		.response_credits(response_credits), .issue_enable(issue_enable),
		.rsp_stage_valid(rsp_stage_valid), .rsp_stage_tag(rsp_stage_tag),
		.rsp_stage_code(rsp_stage_code)
	);

	tag_table u_tag_table (
		.clock(clock), .rstn(rstn), .grant_valid(grant_valid),
		.grant_class(grant_class), .grant_cu_id(grant_cu_id),
		.rsp_stage_valid(rsp_stage_valid), .rsp_stage_tag(rsp_stage_tag),
		.rsp_stage_code(rsp_stage_code), .free_tag(free_tag),
		.tag_available(tag_available), .rsp_valid(rsp_valid), .rsp_class(rsp_class),
		.rsp_cu_id(rsp_cu_id), .rsp_code(rsp_code), .rsp_error(rsp_error)
	);

endmodule

// ==== test/afu_control_tb.sv ====
// Commands are pushed only while disabled and responses only name outstanding tags
`timescale 1ns/1ps

`include "afu_consts.svh"

module afu_control_tb;

	import afu_cmd_pkg::*;
	import afu_rsp_pkg::*;

	localparam logic [31:0] SEED = 32'h77354ed0;
	localparam int NUM_CMDS  = 54;
	localparam int LIMIT     = NUM_CMDS * 40 + 2000;
	localparam int QUIET     = 12;
	localparam int TAG_COUNT = `AFU_TAG_COUNT;
	localparam int CU_W      = `AFU_CU_ID_WIDTH;
	localparam int WORD_W    = `AFU_ADDR_WIDTH + CU_W;

	logic       clock = 1'b0;
	logic       rstn;
	logic       enabled_in;
	credit_t    room;
	logic       wed_cmd_push;
	addr_t      wed_cmd_addr;
	cu_id_t     wed_cmd_cu_id;
	logic       wed_cmd_full;
	logic       write_cmd_push;
	addr_t      write_cmd_addr;
	cu_id_t     write_cmd_cu_id;
	logic       write_cmd_full;
	logic       read_cmd_push;
	addr_t      read_cmd_addr;
	cu_id_t     read_cmd_cu_id;
	logic       read_cmd_full;
	logic       response_valid;
	tag_t       response_tag;
	rsp_code_t  response_code;
	credit_t    response_credits;
	logic       command_valid;
	tag_t       command_tag;
	cmd_code_t  command_code;
	addr_t      command_addr;
	cu_id_t     command_cu_id;
	logic       rsp_valid;
	cmd_class_t rsp_class;
	cu_id_t     rsp_cu_id;
	rsp_code_t  rsp_code;
	logic       rsp_error;

	// Reference model state
	logic [WORD_W-1:0] wed_q[$];
	logic [WORD_W-1:0] write_q[$];
	logic [WORD_W-1:0] read_q[$];
	bit                tag_busy [TAG_COUNT];
	bit                rsp_sent [TAG_COUNT];
	int                tag_class [TAG_COUNT];
	bit [CU_W-1:0]     tag_cu [TAG_COUNT];
	int                rr_ptr;
	int                outstanding;
	int                cmd_count;
	int                rsp_count;
	int                errors;
	int                cycle;
	bit                exp_v0;
	bit                exp_v1;
	int                exp_tag0;
	int                exp_tag1;
	int                exp_cls0;
	int                exp_cls1;
	bit [CU_W-1:0]     exp_cu0;
	bit [CU_W-1:0]     exp_cu1;
	bit [7:0]          exp_code0;
	bit [7:0]          exp_code1;
	bit                run_q;
	int                credit_total;
	int                issued_win;

	afu_control u_dut (.*);

	always #10 clock = ~clock;

	task automatic flag_error(input string msg);
		errors++;
		$display("FAIL %0t: %s", $time, msg);
	endtask

	function automatic int queue_size(input int cls);
		case (cls)
			0: return wed_q.size();
			1: return write_q.size();
			default: return read_q.size();
		endcase
	endfunction

	// First class with work at or after the round-robin pointer
	function automatic int next_class();
		int c;
		int pick;
		pick = -1;
		for (int i = 2; i >= 0; i--) begin
			c = (rr_ptr + i) % 3;
			if (queue_size(c) > 0) begin
				pick = c;
			end
		end
		return pick;
	endfunction

	function automatic int lowest_free_tag();
		int pick;
		pick = -1;
		for (int t = TAG_COUNT - 1; t >= 0; t--) begin
			if (!tag_busy[t]) begin
				pick = t;
			end
		end
		return pick;
	endfunction

	function automatic rsp_code_t random_code();
		case ($urandom % 6)
			0: return RSP_AERROR;
			1: return RSP_FAULT;
			2: return RSP_PAGED;
			default: return RSP_DONE;
		endcase
	endfunction

	//////////////////////////////
	// Reference model
	//////////////////////////////
	always @(posedge clock) begin : model
		int cls;
		int exp_tag;
		logic [WORD_W-1:0] word;
		cmd_code_t exp_code;
		if (rstn) begin
			// Commands are matched before releases since a tag freed on this edge is not yet reusable
			if (command_valid) begin
				cls = next_class();
				exp_tag = lowest_free_tag();
				if (cls < 0 || exp_tag < 0) begin
					flag_error("command issued with nothing queued or no free tag");
				end else begin
					case (cls)
						0: word = wed_q.pop_front();
						1: word = write_q.pop_front();
						default: word = read_q.pop_front();
					endcase
					exp_code = (cls == int'(CLASS_WRITE)) ? `AFU_CODE_WRITE_NA
						: `AFU_CODE_READ_CL_NA;
					assert (command_code == exp_code && command_addr == word[WORD_W-1:CU_W]
						&& command_cu_id == word[CU_W-1:0])
						else flag_error($sformatf("class %0d command fields mismatch", cls));
					assert (command_tag == tag_t'(exp_tag))
						else flag_error($sformatf("tag %0d used, lowest free is %0d",
							command_tag, exp_tag));
					tag_busy[exp_tag]  = 1'b1;
					rsp_sent[exp_tag]  = 1'b0;
					tag_class[exp_tag] = cls;
					tag_cu[exp_tag]    = word[CU_W-1:0];
					outstanding++;
					rr_ptr = (cls + 1) % 3;
				end
				cmd_count++;
			end
			if (exp_v1) begin
				tag_busy[exp_tag1] = 1'b0;
				outstanding--;
				rsp_count++;
			end
			// No buffer ever holds more than eight entries here
			if ((wed_cmd_push && wed_cmd_full) || (write_cmd_push && write_cmd_full)
				|| (read_cmd_push && read_cmd_full)) begin
				flag_error("push refused by a full command buffer");
			end
			if (wed_cmd_push) begin
				wed_q.push_back({wed_cmd_addr, wed_cmd_cu_id});
			end
			if (write_cmd_push) begin
				write_q.push_back({write_cmd_addr, write_cmd_cu_id});
			end
			if (read_cmd_push) begin
				read_q.push_back({read_cmd_addr, read_cmd_cu_id});
			end
		end
	end

	// Expected response trails the bus response by two edges
	always @(posedge clock) begin
		exp_v0    <= rstn && response_valid;
		exp_tag0  <= int'(response_tag) % TAG_COUNT;
		exp_cls0  <= tag_class[int'(response_tag) % TAG_COUNT];
		exp_cu0   <= tag_cu[int'(response_tag) % TAG_COUNT];
		exp_code0 <= response_code;
		exp_v1    <= exp_v0;
		exp_tag1  <= exp_tag0;
		exp_cls1  <= exp_cls0;
		exp_cu1   <= exp_cu0;
		exp_code1 <= exp_code0;
	end

	// Credits granted and commands seen since the last enable
	always @(posedge clock) begin
		cycle <= cycle + 1;
		run_q <= rstn && enabled_in;
		if (!run_q) begin
			credit_total <= int'(room);
			issued_win   <= 0;
		end else begin
			credit_total <= credit_total + (response_valid ? int'(response_credits) : 0);
			issued_win   <= issued_win + (command_valid ? 1 : 0);
		end
	end

	//////////////////////////////
	// Assertions
	//////////////////////////////
	assert property (@(posedge clock) (!rstn && cycle > 2) |-> (!command_valid && !rsp_valid
		&& !rsp_error && !wed_cmd_full && !write_cmd_full && !read_cmd_full
		&& u_dut.u_issue_control.credits == '0))
		else flag_error("outputs or credits not cleared in reset");

	assert property (@(posedge clock) disable iff (!rstn) rsp_valid == exp_v1)
		else flag_error("rsp_valid does not follow response_valid by two cycles");

	assert property (@(posedge clock) disable iff (!rstn) rsp_valid |->
		(int'(rsp_class) == exp_cls1 && rsp_cu_id == exp_cu1 && rsp_code == exp_code1))
		else flag_error($sformatf("response for tag %0d has wrong class, unit or code", exp_tag1));

	assert property (@(posedge clock) disable iff (!rstn)
		rsp_error == (exp_v1 && exp_code1 != RSP_DONE))
		else flag_error("rsp_error does not match the response code");

	assert property (@(posedge clock) disable iff (!rstn)
		command_valid |-> (credit_total - issued_win > 1))
		else flag_error("command issued without a spare credit");

	//////////////////////////////
	// Stimulus tasks
	//////////////////////////////
	task automatic load_cmds(input int n_wed, input int n_write, input int n_read);
		int n_max;
		n_max = (n_wed > n_write) ? n_wed : n_write;
		n_max = (n_read > n_max) ? n_read : n_max;
		for (int i = 0; i < n_max; i++) begin
			@(posedge clock);
			wed_cmd_push    <= (i < n_wed);
			wed_cmd_addr    <= $urandom;
			wed_cmd_cu_id   <= cu_id_t'($urandom);
			write_cmd_push  <= (i < n_write);
			write_cmd_addr  <= $urandom;
			write_cmd_cu_id <= cu_id_t'($urandom);
			read_cmd_push   <= (i < n_read);
			read_cmd_addr   <= $urandom;
			read_cmd_cu_id  <= cu_id_t'($urandom);
		end
		@(posedge clock);
		wed_cmd_push   <= 1'b0;
		write_cmd_push <= 1'b0;
		read_cmd_push  <= 1'b0;
	endtask

	task automatic start_run(input int credits);
		@(posedge clock);
		room <= credit_t'(credits);
		@(posedge clock);
		enabled_in <= 1'b1;
	endtask

	task automatic stop_run();
		@(posedge clock);
		enabled_in <= 1'b0;
		@(posedge clock);
	endtask

	task automatic wait_commands(input int target);
		while (cmd_count < target) begin
			@(negedge clock);
		end
	endtask

	// Answers one random outstanding tag that has no response yet
	task automatic send_response(input int credits, output bit sent);
		int picks[$];
		int t;
		@(negedge clock);
		for (int i = 0; i < TAG_COUNT; i++) begin
			if (tag_busy[i] && !rsp_sent[i]) begin
				picks.push_back(i);
			end
		end
		sent = (picks.size() > 0);
		if (sent) begin
			t = picks[$urandom % picks.size()];
			rsp_sent[t] = 1'b1;
			@(posedge clock);
			response_valid   <= 1'b1;
			response_tag     <= tag_t'(t);
			response_code    <= random_code();
			response_credits <= credit_t'(credits);
			@(posedge clock);
			response_valid <= 1'b0;
		end
	endtask

	task automatic drain_all();
		bit sent;
		bit done;
		done = 1'b0;
		while (!done) begin
			send_response(1, sent);
			if (!sent && outstanding == 0
				&& wed_q.size() + write_q.size() + read_q.size() == 0) begin
				done = 1'b1;
			end
		end
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////
	initial begin : stimulus
		int base;
		bit sent;
		void'($urandom(SEED));
		rstn             <= 1'b0;
		enabled_in       <= 1'b0;
		room             <= '0;
		wed_cmd_push     <= 1'b0;
		wed_cmd_addr     <= '0;
		wed_cmd_cu_id    <= '0;
		write_cmd_push   <= 1'b0;
		write_cmd_addr   <= '0;
		write_cmd_cu_id  <= '0;
		read_cmd_push    <= 1'b0;
		read_cmd_addr    <= '0;
		read_cmd_cu_id   <= '0;
		response_valid   <= 1'b0;
		response_tag     <= '0;
		response_code    <= RSP_DONE;
		response_credits <= '0;
		repeat (10) @(posedge clock);
		rstn <= 1'b1;
		repeat (2) @(posedge clock);

		// Rotating order over preloaded buffers
		base = cmd_count;
		load_cmds(5, 3, 6);
		start_run(40);
		wait_commands(base + 14);
		drain_all();
		stop_run();

		// Room minus one issues before a response returns two credits
		base = cmd_count;
		load_cmds(0, 8, 0);
		start_run(5);
		wait_commands(base + 4);
		repeat (QUIET) @(negedge clock);
		assert (cmd_count == base + 4)
			else flag_error($sformatf("%0d commands issued on room 5", cmd_count - base));
		send_response(2, sent);
		wait_commands(base + 6);
		repeat (QUIET) @(negedge clock);
		assert (cmd_count == base + 6)
			else flag_error("two returned credits did not give exactly two commands");
		drain_all();
		stop_run();

		// Tag exhaustion at sixteen outstanding
		base = cmd_count;
		load_cmds(8, 8, 8);
		start_run(100);
		wait_commands(base + TAG_COUNT);
		repeat (QUIET) @(negedge clock);
		assert (cmd_count == base + TAG_COUNT && outstanding == TAG_COUNT)
			else flag_error("issue did not stop with all tags outstanding");
		drain_all();
		stop_run();

		// Read buffer filled while disabled and drained in order
		load_cmds(0, 0, 8);
		@(negedge clock);
		assert (read_cmd_full && !wed_cmd_full && !write_cmd_full)
			else flag_error("read buffer not full after eight pushes");
		start_run(20);
		drain_all();
		stop_run();
		@(negedge clock);
		assert (!read_cmd_full)
			else flag_error("read buffer still full after draining");

		$display("commands %0d responses %0d errors %0d", cmd_count, rsp_count, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	initial begin : watchdog
		repeat (LIMIT) @(posedge clock);
		$display("Watchdog expired after %0d cycles, the run did not finish", LIMIT);
		$display("commands %0d responses %0d errors %0d", cmd_count, rsp_count, errors);
		$display("tests failed");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+common
common/afu_cmd_pkg.sv
common/afu_rsp_pkg.sv
source/sync_fifo.sv
command/cmd_rr_arbiter.sv
command/issue_control.sv
source/tag_table.sv
source/afu_control.sv
test/afu_control_tb.sv
